// ==== all.f ====
+incdir+.
pgw_pkg.sv
pgw_line_buf.sv
pgw_addr_gen.sv
pgw_md_packer.sv
pgw_write_port.sv
pgw_write_ctrl.sv
pgw_top.sv
tb_pgw_top.sv

// ==== Makefile ====
# Verilator build and run of the page write manager testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -j 0 --top-module tb_pgw_top -f all.f -o sim_pgw
	./obj_dir/sim_pgw | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_pgw_top.sv ====
`timescale 1ns/1ps
`include "pgw_consts.svh"

module tb_pgw_top;

	localparam int NUM_JOBS = 24;
	localparam int RESET_CYCLES = 16;
	localparam int BEATS_PER_JOB = `PGW_PAGE_LINES + 1; // page lines plus metadata
	localparam int CYCLES_PER_BEAT = 40;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES +
		NUM_JOBS * BEATS_PER_JOB * CYCLES_PER_BEAT;
	localparam int MD_REC_BITS = 2 + `PGW_CNT_W + 2 * `PGW_PTR_W;

	logic clk_i;
	logic rst_ni;
	logic job_valid;
	pgw_pkg::pgw_job_t job;
	logic job_ready;
	logic line_valid;
	logic [`PGW_LINE_W-1:0] line_data;
	logic line_ready;
	pgw_pkg::pgw_wr_req_t wr_req;
	pgw_pkg::pgw_wr_rdy_t wr_rdy;
	logic done;

	logic [31:0] lfsr_q = 32'd89774;
	logic drivers_on = 1'b0;
	logic line_taken;
	logic [`PGW_LINE_W-1:0] line_q[$]; // lines still to be offered to the DUT
	logic [`PGW_ADDR_W-1:0] exp_aw_q[$];
	pgw_pkg::pgw_w_t exp_w_q[$];
	logic aw_hold = 1'b0;
	logic w_hold = 1'b0;
	pgw_pkg::pgw_aw_t aw_held;
	pgw_pkg::pgw_w_t w_held;
	int done_count = 0;
	int writes_checked = 0;
	int value_errs = 0;
	int other_errs = 0;

	pgw_top u_dut (
		.clk_i(clk_i), .rst_ni(rst_ni), .job_valid(job_valid), .job(job),
		.job_ready(job_ready), .line_valid(line_valid), .line_data(line_data),
		.line_ready(line_ready), .wr_req(wr_req), .wr_rdy(wr_rdy), .done(done)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[126:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return v;
	endfunction

	// metadata strobe covers every byte that holds a record bit
	function automatic logic [`PGW_LINE_BYTES-1:0] record_strobe();
		logic [`PGW_LINE_BYTES-1:0] s;
		int b;
		s = '0;
		for (b = 0; b < `PGW_LINE_BYTES; b++) begin
			if (b * 8 < MD_REC_BITS) begin
				s[b] = 1'b1;
			end
		end
		return s;
	endfunction

	task automatic value_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
		value_errs++;
	endtask

	task automatic check_idle_outputs();
		if (wr_req.awvalid !== 1'b0) begin
			value_mismatch("awvalid", wr_req.awvalid, 0);
		end
		if (wr_req.wvalid !== 1'b0) begin
			value_mismatch("wvalid", wr_req.wvalid, 0);
		end
		if (done !== 1'b0) begin
			value_mismatch("done", done, 0);
		end
		if (job_ready !== 1'b1) begin
			value_mismatch("job_ready", job_ready, 1);
		end
		if (line_ready !== 1'b1) begin
			value_mismatch("line_ready", line_ready, 1); // buffer empty
		end
	endtask

	// queue the lines and expected writes of one job, then hand it over and wait for done
	task automatic run_job(input int idx);
		pgw_pkg::pgw_job_t jb;
		pgw_pkg::pgw_md_rec_t rec;
		pgw_pkg::pgw_w_t beat;
		logic [127:0] r;
		int n_lines;
		int i;
		int done_before;
		logic accepted;

		@(negedge clk_i);
		r = rand_bits(2);
		jb.compress = (idx == 1) ? 1'b0 : (r[1:0] != 2'b00);
		r = rand_bits(28);
		jb.dst_base = {r[27:0], 4'h0};
		r = rand_bits(4);
		jb.line_cnt = `PGW_CNT_W'(r[3:0]) + `PGW_CNT_W'(1);
		r = rand_bits(`PGW_PTR_W);
		jb.page_ptr = r[`PGW_PTR_W-1:0];
		r = rand_bits(`PGW_PTR_W);
		jb.next_ptr = r[`PGW_PTR_W-1:0];
		n_lines = jb.compress ? int'(jb.line_cnt) : `PGW_PAGE_LINES;

		for (i = 0; i < n_lines; i++) begin
			r = rand_bits(`PGW_LINE_W);
			line_q.push_back(r[`PGW_LINE_W-1:0]);
			exp_aw_q.push_back(jb.dst_base + `PGW_ADDR_W'(i * `PGW_LINE_BYTES));
			beat.data.raw = r[`PGW_LINE_W-1:0];
			beat.strb = '1;
			exp_w_q.push_back(beat);
		end

		rec = '0;
		rec.valid = 1'b1;
		rec.compress = jb.compress;
		rec.line_cnt = `PGW_CNT_W'(n_lines);
		rec.page_ptr = jb.page_ptr;
		rec.next_ptr = jb.next_ptr;
		beat.data.md = rec;
		beat.strb = record_strobe();
		exp_aw_q.push_back(`PGW_MD_BASE + `PGW_ADDR_W'(jb.page_ptr) * `PGW_LINE_BYTES);
		exp_w_q.push_back(beat);
		done_before = done_count;

		@(posedge clk_i);
		#1;
		job_valid = 1'b1;
		job = jb;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk_i);
			accepted = job_ready;
			@(posedge clk_i);
			#1;
		end
		job_valid = 1'b0;

		// no new job may be taken while this one runs
		do begin
			@(negedge clk_i);
			if (job_ready !== 1'b0) begin
				value_mismatch("job_ready while busy", job_ready, 0);
			end
		end while (!done);
		for (i = 0; i < 4 && !job_ready; i++) begin
			@(negedge clk_i);
		end
		if (!job_ready) begin
			$display("job %0d: job_ready did not return after done", idx);
			other_errs++;
		end
		if (done_count != done_before + 1) begin
			$display("job %0d: saw %0d done pulses instead of one", idx,
				done_count - done_before);
			other_errs++;
		end
	endtask

	// line source and write channel back-pressure decide once per cycle
	initial begin
		wait (drivers_on);
		forever begin
			@(negedge clk_i);
			line_taken = line_valid && line_ready;
			@(posedge clk_i);
			#1;
			if (line_taken) begin
				line_q.delete(0);
				line_valid = 1'b0;
			end
			if (!line_valid && line_q.size() > 0 && rand_bits(2) != 0) begin
				line_valid = 1'b1;
				line_data = line_q[0];
			end
			wr_rdy.awready = (rand_bits(2) != 0);
			wr_rdy.wready = (rand_bits(2) != 0);
		end
	end

	// a handshake sampled mid cycle is taken on the next rising edge
	always @(negedge clk_i) begin
		if (rst_ni) begin
			if (aw_hold && !wr_req.awvalid) begin
				$display("awvalid dropped before awready at %0t", $time);
				other_errs++;
			end else if (aw_hold && wr_req.aw !== aw_held) begin
				value_mismatch("awaddr while stalled", wr_req.aw.addr, aw_held.addr);
			end
			if (w_hold && !wr_req.wvalid) begin
				$display("wvalid dropped before wready at %0t", $time);
				other_errs++;
			end else if (w_hold && wr_req.w !== w_held) begin
				value_mismatch("wdata while stalled", wr_req.w.data.raw, w_held.data.raw);
			end

			if (wr_req.awvalid && wr_rdy.awready) begin
				if (exp_aw_q.size() == 0) begin
					$display("address write accepted with none expected at %0t", $time);
					other_errs++;
				end else begin
					if (wr_req.aw.addr !== exp_aw_q[0]) begin
						value_mismatch("awaddr", wr_req.aw.addr, exp_aw_q[0]);
					end
					exp_aw_q.delete(0);
					writes_checked++;
				end
			end
			if (wr_req.wvalid && wr_rdy.wready) begin
				if (exp_w_q.size() == 0) begin
					$display("data beat accepted with none expected at %0t", $time);
					other_errs++;
				end else begin
					if (wr_req.w.data.raw !== exp_w_q[0].data.raw) begin
						value_mismatch("wdata", wr_req.w.data.raw, exp_w_q[0].data.raw);
					end
					if (wr_req.w.strb !== exp_w_q[0].strb) begin
						value_mismatch("wstrb", wr_req.w.strb, exp_w_q[0].strb);
					end
					exp_w_q.delete(0);
				end
			end
			aw_hold = wr_req.awvalid && !wr_rdy.awready;
			aw_held = wr_req.aw;
			w_hold = wr_req.wvalid && !wr_rdy.wready;
			w_held = wr_req.w;

			if (done) begin
				done_count++;
				if (exp_aw_q.size() != 0 || exp_w_q.size() != 0) begin
					$display("done pulsed before all writes of the job were accepted at %0t",
						$time);
					other_errs++;
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("watchdog expired after %0d cycles, %0d jobs done",
			WATCHDOG_CYCLES, done_count);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int j;
		rst_ni = 1'b0;
		job_valid = 1'b0;
		job = '0;
		line_valid = 1'b0;
		line_data = '0;
		wr_rdy = '0;

		repeat (RESET_CYCLES - 1) @(posedge clk_i);
		@(negedge clk_i);
		check_idle_outputs();
		@(posedge clk_i);
		#1;
		rst_ni = 1'b1;
		@(negedge clk_i);
		check_idle_outputs(); // still quiet right after release
		drivers_on = 1'b1;

		for (j = 0; j < NUM_JOBS; j++) begin
			run_job(j);
		end
		repeat (4) @(negedge clk_i);
		if (exp_aw_q.size() != 0 || exp_w_q.size() != 0 || line_q.size() != 0) begin
			$display("writes or lines left over at the end of the run");
			other_errs++;
		end

		$display("jobs %0d, writes checked %0d, value errors %0d, other errors %0d",
			NUM_JOBS, writes_checked, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== pgw_top.sv ====
`timescale 1ns/1ps
`include "pgw_consts.svh"

module pgw_top (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   job_valid,
	input  pgw_pkg::pgw_job_t      job,
	output logic                   job_ready,
	input  logic                   line_valid,
	input  logic [`PGW_LINE_W-1:0] line_data,
	output logic                   line_ready,
	output pgw_pkg::pgw_wr_req_t   wr_req,
	input  pgw_pkg::pgw_wr_rdy_t   wr_rdy,
	output logic                   done
);

	logic buf_full;
	logic buf_not_empty;
	logic [`PGW_LINE_W-1:0] buf_head;
	logic load;
	logic pop;
	logic step;
	logic last_line;
	logic port_idle;
	logic issue;
	logic is_md;
	logic [`PGW_ADDR_W-1:0] line_addr;
	logic [`PGW_ADDR_W-1:0] md_addr;
	logic [`PGW_CNT_W-1:0] lines_done;
	pgw_pkg::pgw_job_t job_q;
	pgw_pkg::pgw_wdata_u md_word;
	logic [`PGW_LINE_BYTES-1:0] md_strb;
	pgw_pkg::pgw_aw_t port_aw;
	pgw_pkg::pgw_w_t port_w;

	assign line_ready = ~buf_full;

	pgw_line_buf u_buf (
		.clk_i(clk_i), .rst_ni(rst_ni),
		.push(line_valid & line_ready), .push_data(line_data), .full(buf_full),
		.pop(pop), .pop_data(buf_head), .not_empty(buf_not_empty)
	);

	pgw_addr_gen u_addr (
		.clk_i(clk_i), .rst_ni(rst_ni), .load(load), .job(job), .step(step),
		.line_addr(line_addr), .md_addr(md_addr), .lines_done(lines_done),
		.last_line(last_line), .job_q(job_q)
	);

	pgw_md_packer u_pack (.job(job_q), .lines_done(lines_done), .md_word(md_word),
		.md_strb(md_strb));

	// page line or metadata record into the port
	always_comb begin
		port_aw.addr = is_md ? md_addr : line_addr;
		port_w.data.raw = is_md ? md_word.raw : buf_head;
		port_w.strb = is_md ? md_strb : '1; // payload lines are full writes
	end

	pgw_write_port u_port (
		.clk_i(clk_i), .rst_ni(rst_ni), .issue(issue), .aw(port_aw), .w(port_w),
		.wr_req(wr_req), .wr_rdy(wr_rdy), .idle(port_idle)
	);

	pgw_write_ctrl u_ctrl (
		.clk_i(clk_i), .rst_ni(rst_ni), .job_valid(job_valid), .job_ready(job_ready),
		.load(load), .buf_not_empty(buf_not_empty), .pop(pop), .step(step),
		.last_line(last_line), .port_idle(port_idle), .issue(issue), .is_md(is_md),
		.done(done)
	);

endmodule

// ==== pgw_write_ctrl.sv ====
`timescale 1ns/1ps

module pgw_write_ctrl (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic job_valid,
	output logic job_ready,
	output logic load,
	input  logic buf_not_empty,
	output logic pop,
	output logic step,
	input  logic last_line,
	input  logic port_idle,
	output logic issue,
	output logic is_md,
	output logic done
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LINES,
		ST_MD_ISSUE,
		ST_MD_WAIT,
		ST_DONE
	} state_e;

	state_e state;
	state_e next_state;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		job_ready = 1'b0;
		load = 1'b0;
		pop = 1'b0;
		step = 1'b0;
		issue = 1'b0;
		is_md = 1'b0;
		done = 1'b0;

		case (state)
			ST_IDLE: begin
				job_ready = 1'b1;
				if (job_valid) begin
					load = 1'b1; // latch job, clear line count
					next_state = ST_LINES;
				end
			end

			// one line in flight at a time
			ST_LINES: begin
				if (port_idle) begin
					if (last_line) begin
						next_state = ST_MD_ISSUE; // last page line is accepted
					end else if (buf_not_empty) begin
						pop = 1'b1;
						step = 1'b1;
						issue = 1'b1;
					end
				end
			end

			// port is known idle here, metadata goes out now
			ST_MD_ISSUE: begin
				issue = 1'b1;
				is_md = 1'b1;
				next_state = ST_MD_WAIT;
			end

			ST_MD_WAIT: begin
				if (port_idle) begin
					done = 1'b1; // metadata AW and W both taken
					next_state = ST_DONE;
				end
			end

			// turnaround before job_ready comes back
			ST_DONE: begin
				next_state = ST_IDLE;
			end

			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

endmodule

// ==== pgw_write_port.sv ====
`timescale 1ns/1ps

module pgw_write_port (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 issue,
	input  pgw_pkg::pgw_aw_t     aw,
	input  pgw_pkg::pgw_w_t      w,
	output pgw_pkg::pgw_wr_req_t wr_req,
	input  pgw_pkg::pgw_wr_rdy_t wr_rdy,
	output logic                 idle
);

	logic awvalid_q;
	logic wvalid_q;
	pgw_pkg::pgw_aw_t aw_q;
	pgw_pkg::pgw_w_t w_q;

	// payload only changes on issue, so it is stable while valid waits
	always_ff @(posedge clk_i) begin
		if (issue) begin
			aw_q <= aw;
			w_q <= w;
		end
	end

	// each channel drops its valid on its own handshake
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			awvalid_q <= 1'b0;
			wvalid_q <= 1'b0;
		end else if (issue) begin
			awvalid_q <= 1'b1;
			wvalid_q <= 1'b1;
		end else begin
			if (awvalid_q && wr_rdy.awready) begin
				awvalid_q <= 1'b0;
			end
			if (wvalid_q && wr_rdy.wready) begin
				wvalid_q <= 1'b0;
			end
		end
	end

	always_comb begin
		wr_req.awvalid = awvalid_q;
		wr_req.aw = aw_q;
		wr_req.wvalid = wvalid_q;
		wr_req.w = w_q;
	end

	assign idle = ~awvalid_q & ~wvalid_q; // both channels drained

endmodule

// ==== pgw_md_packer.sv ====
`timescale 1ns/1ps
`include "pgw_consts.svh"

module pgw_md_packer (
	input  pgw_pkg::pgw_job_t          job,
	input  logic [`PGW_CNT_W-1:0]      lines_done,
	output pgw_pkg::pgw_wdata_u        md_word,
	output logic [`PGW_LINE_BYTES-1:0] md_strb
);

	// bytes touched by the record, the last one may be partly padding
	localparam int REC_BYTES = (`PGW_MD_REC_BITS + 7) / 8;
	localparam int PAD_BYTES = `PGW_LINE_BYTES - REC_BYTES;

	always_comb begin
		md_word = '0; // padding goes out as zero
		md_word.md.valid = 1'b1;
		md_word.md.compress = job.compress;
		md_word.md.line_cnt = lines_done; // lines actually written
		md_word.md.page_ptr = job.page_ptr;
		md_word.md.next_ptr = job.next_ptr;
	end

	// only the record bytes are written
	assign md_strb = {{PAD_BYTES{1'b0}}, {REC_BYTES{1'b1}}};

endmodule

// ==== pgw_addr_gen.sv ====
`timescale 1ns/1ps
`include "pgw_consts.svh"

module pgw_addr_gen (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   load,
	input  pgw_pkg::pgw_job_t      job,
	input  logic                   step,
	output logic [`PGW_ADDR_W-1:0] line_addr,
	output logic [`PGW_ADDR_W-1:0] md_addr,
	output logic [`PGW_CNT_W-1:0]  lines_done,
	output logic                   last_line,
	output pgw_pkg::pgw_job_t      job_q
);

	localparam logic [`PGW_CNT_W-1:0] PAGE_LINES = `PGW_PAGE_LINES;
	localparam logic [`PGW_ADDR_W-1:0] LINE_BYTES = `PGW_LINE_BYTES;
	localparam logic [`PGW_ADDR_W-1:0] MD_BASE = `PGW_MD_BASE;

	logic [`PGW_CNT_W-1:0] target;

	// job fields stay put for the whole page
	always_ff @(posedge clk_i) begin
		if (load) begin
			job_q <= job;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			lines_done <= '0;
		end else if (load) begin
			lines_done <= '0;
		end else if (step) begin
			lines_done <= lines_done + 1'b1;
		end
	end

	// a decompressed page ignores line_cnt
	assign target = job_q.compress ? job_q.line_cnt : PAGE_LINES;
	assign last_line = (lines_done == target);

	assign line_addr = job_q.dst_base + (`PGW_ADDR_W'(lines_done) * LINE_BYTES);
	assign md_addr = MD_BASE + (`PGW_ADDR_W'(job_q.page_ptr) * LINE_BYTES); // one line per page

endmodule

// ==== pgw_line_buf.sv ====
`timescale 1ns/1ps
`include "pgw_consts.svh"

module pgw_line_buf (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   push,
	input  logic [`PGW_LINE_W-1:0] push_data,
	output logic                   full,
	input  logic                   pop,
	output logic [`PGW_LINE_W-1:0] pop_data,
	output logic                   not_empty
);

	localparam int DEPTH = `PGW_BUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
	localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

	logic [`PGW_LINE_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == FULL_CNT);
	assign not_empty = (count != '0);
	assign do_push = push & ~full; // writes into a full buffer are dropped
	assign do_pop = pop & not_empty;
	assign pop_data = mem[rd_ptr]; // head is visible without a read cycle

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or push and pop together
			endcase
		end
	end

endmodule

// ==== pgw_pkg.sv ====
`include "pgw_consts.svh"

package pgw_pkg;

	// one page write job
	typedef struct packed {
		logic                   compress; // 1: compressed page
		logic [`PGW_ADDR_W-1:0] dst_base; // line aligned
		logic [`PGW_CNT_W-1:0]  line_cnt; // compressed lines, 1..16
		logic [`PGW_PTR_W-1:0]  page_ptr;
		logic [`PGW_PTR_W-1:0]  next_ptr;
	} pgw_job_t;

	// metadata record, valid sits in bit 0
	typedef struct packed {
		logic [`PGW_LINE_W-`PGW_MD_REC_BITS-1:0] pad;
		logic [`PGW_PTR_W-1:0]                   next_ptr;
		logic [`PGW_PTR_W-1:0]                   page_ptr;
		logic [`PGW_CNT_W-1:0]                   line_cnt;
		logic                                    compress;
		logic                                    valid;
	} pgw_md_rec_t;

	// one line on the W channel, either payload or a metadata record
	typedef union packed {
		logic [`PGW_LINE_W-1:0] raw;
		pgw_md_rec_t            md;
	} pgw_wdata_u;

	typedef struct packed {
		logic [`PGW_ADDR_W-1:0] addr;
	} pgw_aw_t;

	typedef struct packed {
		pgw_wdata_u                 data;
		logic [`PGW_LINE_BYTES-1:0] strb;
	} pgw_w_t;

	typedef struct packed {
		logic    awvalid;
		pgw_aw_t aw;
		logic    wvalid;
		pgw_w_t  w;
	} pgw_wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
	} pgw_wr_rdy_t;

endpackage

// ==== pgw_consts.svh ====
`ifndef PGW_CONSTS_SVH
`define PGW_CONSTS_SVH

// address and line geometry
`define PGW_ADDR_W      32
`define PGW_LINE_BYTES  16
`define PGW_LINE_W      128

// a decompressed page is always this many lines
`define PGW_PAGE_LINES  16

`define PGW_MD_BASE     32'h0008_0000 // metadata region, one line per page
`define PGW_BUF_DEPTH   8             // payload lines waiting for the channels
`define PGW_PTR_W       16

// line counter, holds 0 up to PGW_PAGE_LINES
`define PGW_CNT_W       5

// used bits of the metadata record, padding fills the rest of the line
`define PGW_MD_REC_BITS (2 + `PGW_CNT_W + 2 * `PGW_PTR_W)

`endif
